// File: bench/immu_tb.sv
`timescale 1ns/10ps

module immu_tb;

	import immu_cfg_pkg::*;
	import immu_tag_pkg::*;

	localparam int num_sets = 64;
	localparam int idx_bits = $clog2(num_sets);

	// Fill, plain reads, retried reads, mixed traffic
	localparam int num_ops = 2 * num_sets + 32 + 8 + 200;
	localparam int watchdog_ns = num_ops * 10 * 8;

	// Bits that the registers keep
	localparam spr_data_t mr_mask = 32'hFFFF_E001;
	localparam spr_data_t tr_mask = 32'hFFFF_E0C0;

	logic       clk;
	logic       rst;
	logic       immu_en_i;
	logic       supv_i;
	addr_t      icpu_adr_i;
	logic       icpu_cycstb_i;
	addr_t      icpu_adr_o;
	fetch_tag_t icpu_tag_o;
	logic       icpu_rty_o;
	logic       icpu_err_o;
	logic       spr_cs_i;
	logic       spr_write_i;
	spr_addr_t  spr_addr_i;
	spr_data_t  spr_dat_i;
	spr_data_t  spr_dat_o;
	logic       qmem_rty_i;
	logic       qmem_err_i;
	fetch_tag_t qmem_tag_i;
	addr_t      qmem_adr_o;
	logic       qmem_cycstb_o;

	// Reference copy of the ITLB, masked words
	spr_data_t model_mr [num_sets];
	spr_data_t model_tr [num_sets];

	logic [31:0] rng_state;

	immu_top #(.num_sets(num_sets)) dut (
		.clk(clk), .rst(rst), .immu_en_i(immu_en_i), .supv_i(supv_i),
		.icpu_adr_i(icpu_adr_i), .icpu_cycstb_i(icpu_cycstb_i), .icpu_adr_o(icpu_adr_o),
		.icpu_tag_o(icpu_tag_o), .icpu_rty_o(icpu_rty_o), .icpu_err_o(icpu_err_o),
		.spr_cs_i(spr_cs_i), .spr_write_i(spr_write_i), .spr_addr_i(spr_addr_i),
		.spr_dat_i(spr_dat_i), .spr_dat_o(spr_dat_o), .qmem_rty_i(qmem_rty_i),
		.qmem_err_i(qmem_err_i), .qmem_tag_i(qmem_tag_i), .qmem_adr_o(qmem_adr_o),
		.qmem_cycstb_o(qmem_cycstb_o)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Match word whose vpn indexes back to its own set, valid 3 of 4 times
	function automatic spr_data_t make_mr(input int idx);
		spr_data_t w;
		logic [31:0] r;
		w = next_rand();
		r = next_rand();
		w[page_bits +: idx_bits] = idx[idx_bits-1:0];
		w[0] = |r[1:0];
		return w;
	endfunction

	// Translate word, each execute bit set 3 of 4 times
	function automatic spr_data_t make_tr();
		spr_data_t w;
		logic [31:0] r;
		w = next_rand();
		r = next_rand();
		w[7] = |r[1:0];
		w[6] = |r[3:2];
		return w;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// One-cycle SPR write with translation off
	task automatic spr_write(input logic to_tr, input int idx, input spr_data_t data);
		immu_en_i = 1'b0;
		icpu_cycstb_i = 1'b0;
		qmem_rty_i = 1'b0;
		qmem_err_i = 1'b0;
		spr_cs_i = 1'b1;
		spr_write_i = 1'b1;
		spr_addr_i = (to_tr ? 16'h1300 : 16'h1200) + spr_addr_t'(idx);
		spr_dat_i = data;
		if (to_tr) begin
			model_tr[idx] = data & tr_mask;
		end else begin
			model_mr[idx] = data & mr_mask;
		end
		@(negedge clk);
		spr_cs_i = 1'b0;
		spr_write_i = 1'b0;
	endtask

	// Translated read is retried once, so it is held two cycles
	task automatic spr_read(input logic to_tr, input int idx, input logic en);
		spr_data_t exp;
		exp = to_tr ? model_tr[idx] : model_mr[idx];
		immu_en_i = en;
		icpu_cycstb_i = 1'b0;
		qmem_rty_i = 1'b0;
		qmem_err_i = 1'b0;
		spr_cs_i = 1'b1;
		spr_write_i = 1'b0;
		spr_addr_i = (to_tr ? 16'h1300 : 16'h1200) + spr_addr_t'(idx);
		spr_dat_i = next_rand();
		#1;
		check_value("icpu_rty_o in first SPR cycle", 32'(icpu_rty_o), 32'(en));
		@(negedge clk);
		if (en) begin
			check_value("icpu_rty_o in second SPR cycle", 32'(icpu_rty_o), 32'd0);
			@(negedge clk);
		end
		check_value("spr_dat_o", spr_dat_o, exp);
		spr_cs_i = 1'b0;
	endtask

	// Address held 3 cycles, result checked in the last one
	task automatic fetch(input logic en, input logic supv, input addr_t adr, input logic stb,
		input logic q_rty, input logic q_err, input fetch_tag_t q_tag);
		addr_t prev_adr;
		spr_data_t mr;
		spr_data_t tr;
		logic [idx_bits-1:0] idx;
		logic hit;
		logic perm;
		logic miss;
		logic fault;
		addr_t exp_adr;
		logic exp_stb;
		logic exp_err;
		fetch_tag_t exp_tag;
		prev_adr = icpu_adr_i;
		immu_en_i = en;
		supv_i = supv;
		icpu_adr_i = adr;
		icpu_cycstb_i = stb;
		qmem_rty_i = q_rty;
		qmem_err_i = q_err;
		qmem_tag_i = q_tag;
		spr_cs_i = 1'b0;
		spr_write_i = 1'b0;
		#1;
		// Output register still shows last cycle's address
		check_value("icpu_adr_o one cycle late", icpu_adr_o, prev_adr);
		idx = adr[page_bits +: idx_bits];
		mr = model_mr[idx];
		tr = model_tr[idx];
		hit = mr[0] && (mr[31:page_bits] == adr[31:page_bits]);
		perm = supv ? tr[6] : tr[7];
		miss = en && !hit;
		fault = en && !perm;
		exp_adr = en ? {tr[31:page_bits], adr[page_bits-1:0]} : adr;
		exp_stb = en ? (!miss && !fault) : stb;
		exp_err = miss || fault || q_err;
		exp_tag = miss ? tag_tlb_miss : (fault ? tag_page_fault : q_tag);
		repeat (3) @(negedge clk);
		check_value("icpu_adr_o", icpu_adr_o, adr);
		check_value("qmem_cycstb_o", 32'(qmem_cycstb_o), 32'(exp_stb));
		check_value("icpu_err_o", 32'(icpu_err_o), 32'(exp_err));
		check_value("icpu_tag_o", 32'(icpu_tag_o), 32'(exp_tag));
		check_value("icpu_rty_o", 32'(icpu_rty_o), 32'(q_rty));
		check_value("spr_dat_o unselected", spr_dat_o, 32'd0);
		// Physical address only matters on a clean translation
		if (!miss && !fault) begin
			check_value("qmem_adr_o", qmem_adr_o, exp_adr);
		end
	endtask

	// Run limit from the op count
	initial begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		logic [idx_bits-1:0] idx;
		vpn_t vpn;
		rng_state = 32'd7;
		clk = 1'b0;
		rst = 1'b1;
		immu_en_i = 1'b0;
		supv_i = 1'b0;
		icpu_adr_i = '0;
		icpu_cycstb_i = 1'b0;
		spr_cs_i = 1'b0;
		spr_write_i = 1'b0;
		spr_addr_i = '0;
		spr_dat_i = '0;
		qmem_rty_i = 1'b0;
		qmem_err_i = 1'b0;
		qmem_tag_i = '0;
		for (int i = 0; i < num_sets; i++) begin
			model_mr[i] = '0;
			model_tr[i] = '0;
		end
		repeat (2) @(negedge clk);
		rst = 1'b0;
		#1;
		// Reset state with quiet inputs
		check_value("icpu_adr_o after reset", icpu_adr_o, 32'h0000_0100);
		check_value("qmem_cycstb_o after reset", 32'(qmem_cycstb_o), 32'd0);
		check_value("icpu_rty_o after reset", 32'(icpu_rty_o), 32'd0);
		check_value("icpu_err_o after reset", 32'(icpu_err_o), 32'd0);
		check_value("qmem_adr_o after reset", qmem_adr_o, 32'd0);
		@(negedge clk);
		for (int s = 0; s < num_sets; s++) begin
			spr_write(1'b0, s, make_mr(s));
			spr_write(1'b1, s, make_tr());
		end
		// Plain reads, then reads under translation
		repeat (32) begin
			r = next_rand();
			spr_read(r[8], int'(r[idx_bits-1:0]), 1'b0);
		end
		repeat (8) begin
			r = next_rand();
			spr_read(r[8], int'(r[idx_bits-1:0]), 1'b1);
		end
		// Mixed traffic
		repeat (200) begin
			r = next_rand();
			r2 = next_rand();
			idx = r2[idx_bits-1:0];
			if (r[2:0] == 3'd0) begin
				if (r[3]) begin
					spr_write(1'b1, int'(idx), make_tr());
				end else begin
					spr_write(1'b0, int'(idx), make_mr(int'(idx)));
				end
			end else if (r[2:0] == 3'd1) begin
				spr_read(r[4], int'(idx), r[5]);
			end else if (r[2:1] == 2'b01) begin
				fetch(1'b0, r2[0], next_rand(), r2[1], r2[3:2] == 2'd0, r2[5:4] == 2'd0,
					r2[9:6]);
			end else begin
				// Mostly the stored page, sometimes a foreign one
				if (r2[9:8] != 2'd0) begin
					vpn = model_mr[idx][31:page_bits];
				end else begin
					vpn = r[31:page_bits];
					vpn[idx_bits-1:0] = idx;
				end
				fetch(1'b1, r2[10], {vpn, r2[31:19]}, 1'b1, r2[12:11] == 2'd0,
					r2[14:13] == 2'd0, r2[18:15]);
			end
		end
		$display("Test passed");
		$finish;
	end

endmodule

// File: hw/immu_cfg_pkg.sv
package immu_cfg_pkg;

	// Fetch and physical address width
	localparam int addr_bits = 32;

	// 8 KB pages
	localparam int page_bits = 13;

	// Page number width above the offset
	localparam int vpn_bits = addr_bits - page_bits;

	// SPR bus widths
	localparam int spr_addr_bits = 16;
	localparam int spr_data_bits = 32;

	typedef logic [addr_bits-1:0] addr_t;
	typedef logic [vpn_bits-1:0] vpn_t;
	typedef logic [vpn_bits-1:0] ppn_t;
	typedef logic [spr_addr_bits-1:0] spr_addr_t;
	typedef logic [spr_data_bits-1:0] spr_data_t;

	// Match register layout, vpn sits in 31..13
	localparam int mr_v_bit = 0;

	// Translate register layout, ppn sits in 31..13
	localparam int tr_uxe_bit = 7;
	localparam int tr_sxe_bit = 6;

	// Fetch address seen by the CPU after reset
	localparam addr_t reset_vector = 32'h0000_0100;

endpackage

// File: hw/immu_fetch_ctrl.sv
`timescale 1ns/10ps

module immu_fetch_ctrl (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      immu_en_i,
	input  logic                      supv_i,
	input  immu_cfg_pkg::addr_t       icpu_adr_i,
	input  logic                      icpu_cycstb_i,
	input  logic                      spr_cs_i,
	input  logic                      hit_i,
	input  immu_cfg_pkg::ppn_t        ppn_i,
	input  logic                      uxe_i,
	input  logic                      sxe_i,
	input  logic                      qmem_rty_i,
	input  logic                      qmem_err_i,
	input  immu_tag_pkg::fetch_tag_t  qmem_tag_i,
	output logic                      tlb_en_o,
	output logic                      spr_gate_o,
	output immu_cfg_pkg::addr_t       qmem_adr_o,
	output logic                      qmem_cycstb_o,
	output immu_tag_pkg::fetch_tag_t  icpu_tag_o,
	output logic                      icpu_rty_o,
	output logic                      icpu_err_o
);

	import immu_cfg_pkg::*;
	import immu_tag_pkg::*;

	// Page of the current and the previous fetch address
	vpn_t cur_vpn;
	vpn_t vpn_r;
	logic [page_bits-1:0] offset;

	logic page_cross;
	logic en_r;
	logic dis_spr;
	logic done;
	logic miss;
	logic fault;

	assign cur_vpn = icpu_adr_i[addr_bits-1:page_bits];
	assign offset  = icpu_adr_i[page_bits-1:0];

	// Previous page that also forms the untranslated upper address
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vpn_r <= '0;
		end else begin
			vpn_r <= cur_vpn;
		end
	end

	// Set only in the first cycle on a new page
	assign page_cross = (cur_vpn != vpn_r);

	// Lookup runs on every translated fetch cycle
	assign tlb_en_o = immu_en_i & icpu_cycstb_i;

	// SPR access passes only in its first cycle
	assign spr_gate_o = spr_cs_i & ~dis_spr;

	// Set by an SPR access under retry
	// dropped again once the retry goes away
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dis_spr <= 1'b0;
		end else if (!icpu_rty_o) begin
			dis_spr <= 1'b0;
		end else if (spr_cs_i) begin
			dis_spr <= 1'b1;
		end
	end

	// Lookup result is valid one cycle later
	// an SPR cycle spoils it
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			en_r <= 1'b0;
		end else begin
			en_r <= tlb_en_o & ~spr_gate_o;
		end
	end

	// Result usable only within the same page
	assign done = en_r & ~page_cross;

	// No entry for this page
	assign miss = done & ~hit_i;

	// Execute bit for the current mode is clear
	assign fault = done & ((~supv_i & ~uxe_i) | (supv_i & ~sxe_i));

	// Held page until the lookup is done
	always_comb begin
		if (done) begin
			qmem_adr_o = {ppn_i, offset};
		end else begin
			qmem_adr_o = {vpn_r, offset};
		end
	end

	// Request is cut on a page change and on any translation error
	always_comb begin
		if (immu_en_i) begin
			qmem_cycstb_o = icpu_cycstb_i & ~page_cross & done & ~(miss | fault);
		end else begin
			qmem_cycstb_o = icpu_cycstb_i & ~page_cross;
		end
	end

	// Miss first, then fault, then whatever memory says
	always_comb begin
		if (miss) begin
			icpu_tag_o = tag_tlb_miss;
		end else if (fault) begin
			icpu_tag_o = tag_page_fault;
		end else begin
			icpu_tag_o = qmem_tag_i;
		end
	end

	assign icpu_err_o = miss | fault | qmem_err_i;

	// Retry the fetch while the ITLB is being accessed
	assign icpu_rty_o = qmem_rty_i | (spr_gate_o & immu_en_i);

	// No memory request alongside a translation error
	a_no_strobe_on_err: assert property (@(posedge clk) disable iff (rst)
		qmem_cycstb_o |-> !(miss || fault))
	else $error("immu_fetch_ctrl: memory strobe with a translation error");

endmodule

// File: hw/immu_tag_pkg.sv
package immu_tag_pkg;

	// Tag returned with each fetch
	typedef logic [3:0] fetch_tag_t;

	// No exception
	localparam fetch_tag_t tag_none = 4'h0;

	// Translation missing in the ITLB
	localparam fetch_tag_t tag_tlb_miss = 4'hD;

	// Execute not permitted for the current mode
	localparam fetch_tag_t tag_page_fault = 4'hC;

	// ITLB match registers, 0x1200 and up
	localparam logic [15:0] spr_itlb_mr_base = 16'h1200;

	// ITLB translate registers, 0x1300 and up
	localparam logic [15:0] spr_itlb_tr_base = 16'h1300;

endpackage

// File: hw/immu_top.sv
`timescale 1ns/10ps

module immu_top #(
	parameter int num_sets = 64
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      immu_en_i,
	input  logic                      supv_i,
	input  immu_cfg_pkg::addr_t       icpu_adr_i,
	input  logic                      icpu_cycstb_i,
	output immu_cfg_pkg::addr_t       icpu_adr_o,
	output immu_tag_pkg::fetch_tag_t  icpu_tag_o,
	output logic                      icpu_rty_o,
	output logic                      icpu_err_o,
	input  logic                      spr_cs_i,
	input  logic                      spr_write_i,
	input  immu_cfg_pkg::spr_addr_t   spr_addr_i,
	input  immu_cfg_pkg::spr_data_t   spr_dat_i,
	output immu_cfg_pkg::spr_data_t   spr_dat_o,
	input  logic                      qmem_rty_i,
	input  logic                      qmem_err_i,
	input  immu_tag_pkg::fetch_tag_t  qmem_tag_i,
	output immu_cfg_pkg::addr_t       qmem_adr_o,
	output logic                      qmem_cycstb_o
);

	import immu_cfg_pkg::*;

	localparam int idx_bits = $clog2(num_sets);

	// SPR decode to array
	logic [idx_bits-1:0] spr_idx;
	logic                mr_we;
	logic                tr_we;
	logic                sel_tr;
	spr_data_t           rd_data;

	// Write strobes after the first-cycle gate
	logic mr_we_g;
	logic tr_we_g;

	// Fetch control to and from the array
	logic spr_gate;
	logic tlb_en;
	logic hit;
	ppn_t ppn;
	logic uxe;
	logic sxe;

	// CPU sees its fetch address one cycle late
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			icpu_adr_o <= reset_vector;
		end else begin
			icpu_adr_o <= icpu_adr_i;
		end
	end

	// Repeated SPR cycles under retry do not write again
	assign mr_we_g = mr_we & spr_gate;
	assign tr_we_g = tr_we & spr_gate;

	itlb_spr_decode #(.num_sets(num_sets)) u_decode (
		.spr_cs_i(spr_cs_i), .spr_write_i(spr_write_i), .spr_addr_i(spr_addr_i),
		.mr_we_o(mr_we), .tr_we_o(tr_we), .sel_tr_o(sel_tr), .spr_idx_o(spr_idx),
		.rd_data_i(rd_data), .spr_dat_o(spr_dat_o)
	);

	itlb_array #(.num_sets(num_sets)) u_array (
		.clk(clk), .rst(rst), .tlb_en_i(tlb_en), .vaddr_i(icpu_adr_i),
		.mr_we_i(mr_we_g), .tr_we_i(tr_we_g), .sel_tr_i(sel_tr), .spr_idx_i(spr_idx),
		.spr_dat_i(spr_dat_i), .rd_data_o(rd_data), .hit_o(hit), .ppn_o(ppn),
		.uxe_o(uxe), .sxe_o(sxe)
	);

	immu_fetch_ctrl u_fetch (
		.clk(clk), .rst(rst), .immu_en_i(immu_en_i), .supv_i(supv_i),
		.icpu_adr_i(icpu_adr_i), .icpu_cycstb_i(icpu_cycstb_i), .spr_cs_i(spr_cs_i),
		.hit_i(hit), .ppn_i(ppn), .uxe_i(uxe), .sxe_i(sxe),
		.qmem_rty_i(qmem_rty_i), .qmem_err_i(qmem_err_i), .qmem_tag_i(qmem_tag_i),
		.tlb_en_o(tlb_en), .spr_gate_o(spr_gate), .qmem_adr_o(qmem_adr_o),
		.qmem_cycstb_o(qmem_cycstb_o), .icpu_tag_o(icpu_tag_o),
		.icpu_rty_o(icpu_rty_o), .icpu_err_o(icpu_err_o)
	);

endmodule

// File: hw/itlb_array.sv
`timescale 1ns/10ps

module itlb_array #(
	parameter int num_sets = 64,
	localparam int idx_bits = $clog2(num_sets)
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      tlb_en_i,
	input  immu_cfg_pkg::addr_t       vaddr_i,
	input  logic                      mr_we_i,
	input  logic                      tr_we_i,
	input  logic                      sel_tr_i,
	input  logic [idx_bits-1:0]       spr_idx_i,
	input  immu_cfg_pkg::spr_data_t   spr_dat_i,
	output immu_cfg_pkg::spr_data_t   rd_data_o,
	output logic                      hit_o,
	output immu_cfg_pkg::ppn_t        ppn_o,
	output logic                      uxe_o,
	output logic                      sxe_o
);

	import immu_cfg_pkg::*;

	// Match registers, only vpn and valid are kept
	vpn_t                mr_vpn [num_sets];
	logic [num_sets-1:0] mr_v;

	// Translate registers, ppn and execute permissions
	ppn_t                tr_ppn [num_sets];
	logic [num_sets-1:0] tr_uxe;
	logic [num_sets-1:0] tr_sxe;

	// Lookup index and page of the fetch address
	logic [idx_bits-1:0] lk_idx;
	vpn_t                cur_vpn;

	// Registered lookup result
	vpn_t lk_vpn;
	logic lk_v;
	ppn_t lk_ppn;
	logic lk_uxe;
	logic lk_sxe;

	// SPR views of the indexed entry
	spr_data_t mr_word;
	spr_data_t tr_word;

	assign cur_vpn = vaddr_i[addr_bits-1:page_bits];

	// Index bits just above the page offset
	assign lk_idx = vaddr_i[page_bits +: idx_bits];

	// Register file written from the SPR port
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < num_sets; i++) begin
				mr_vpn[i] <= '0;
				tr_ppn[i] <= '0;
			end
			mr_v   <= '0;
			tr_uxe <= '0;
			tr_sxe <= '0;
		end else begin
			if (mr_we_i) begin
				mr_vpn[spr_idx_i] <= spr_dat_i[addr_bits-1:page_bits];
				mr_v[spr_idx_i]   <= spr_dat_i[mr_v_bit];
			end
			if (tr_we_i) begin
				tr_ppn[spr_idx_i] <= spr_dat_i[addr_bits-1:page_bits];
				tr_uxe[spr_idx_i] <= spr_dat_i[tr_uxe_bit];
				tr_sxe[spr_idx_i] <= spr_dat_i[tr_sxe_bit];
			end
		end
	end

	// Lookup stage, holds its value while the fetch is idle
	always_ff @(posedge clk) begin
		if (tlb_en_i) begin
			lk_vpn <= mr_vpn[lk_idx];
			lk_v   <= mr_v[lk_idx];
			lk_ppn <= tr_ppn[lk_idx];
			lk_uxe <= tr_uxe[lk_idx];
			lk_sxe <= tr_sxe[lk_idx];
		end
	end

	// Compare against the page held now, not the one sampled
	assign hit_o = lk_v & (lk_vpn == cur_vpn);
	assign ppn_o = lk_ppn;
	assign uxe_o = lk_uxe;
	assign sxe_o = lk_sxe;

	// Unimplemented bits read back as zero
	always_comb begin
		mr_word = '0;
		mr_word[addr_bits-1:page_bits] = mr_vpn[spr_idx_i];
		mr_word[mr_v_bit] = mr_v[spr_idx_i];
		tr_word = '0;
		tr_word[addr_bits-1:page_bits] = tr_ppn[spr_idx_i];
		tr_word[tr_uxe_bit] = tr_uxe[spr_idx_i];
		tr_word[tr_sxe_bit] = tr_sxe[spr_idx_i];
	end

	assign rd_data_o = sel_tr_i ? tr_word : mr_word;

	// Decoded write index stays inside the array
	a_idx_range: assert property (@(posedge clk) disable iff (rst)
		(mr_we_i || tr_we_i) |-> (int'(spr_idx_i) < num_sets))
	else $error("itlb_array: write index out of range");

endmodule

// File: hw/itlb_spr_decode.sv
`timescale 1ns/10ps

module itlb_spr_decode #(
	parameter int num_sets = 64,
	localparam int idx_bits = $clog2(num_sets)
) (
	input  logic                      spr_cs_i,
	input  logic                      spr_write_i,
	input  immu_cfg_pkg::spr_addr_t   spr_addr_i,
	output logic                      mr_we_o,
	output logic                      tr_we_o,
	output logic                      sel_tr_o,
	output logic [idx_bits-1:0]       spr_idx_o,
	input  immu_cfg_pkg::spr_data_t   rd_data_i,
	output immu_cfg_pkg::spr_data_t   spr_dat_o
);

	import immu_tag_pkg::*;

	logic mr_grp;
	logic tr_grp;
	logic spr_wr;

	// Group is picked by the upper address byte
	// 0x12xx match, 0x13xx translate
	assign mr_grp = (spr_addr_i[15:8] == spr_itlb_mr_base[15:8]);
	assign tr_grp = (spr_addr_i[15:8] == spr_itlb_tr_base[15:8]);

	// Set index from the low address bits
	// addresses past num_sets alias back into the array
	assign spr_idx_o = spr_addr_i[idx_bits-1:0];

	// Read mux select for the array
	assign sel_tr_o = tr_grp;

	// Write cycle addressed to the ITLB
	assign spr_wr = spr_cs_i & spr_write_i;

	// One strobe per group
	assign mr_we_o = spr_wr & mr_grp;
	assign tr_we_o = spr_wr & tr_grp;

	// Read data only while selected, zero otherwise
	always_comb begin
		if (spr_cs_i) begin
			spr_dat_o = rd_data_i;
		end else begin
			spr_dat_o = '0;
		end
	end

	// Groups are exclusive so a write hits one register file only
	always_comb begin
		assert (!(mr_we_o && tr_we_o))
		else $error("itlb_spr_decode: both write strobes high");
	end

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the IMMU testbench with Verilator
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -j 0 \
	--top-module immu_tb \
	--Mdir build/obj_dir \
	-f sources.f

sim_status=0
./build/obj_dir/Vimmu_tb > build/sim.log 2>&1 || sim_status=$?
cat build/sim.log

if grep -q "^Test passed$" build/sim.log; then
	exit 0
else
	echo "simulation failed (exit status $sim_status)"
	exit 1
fi

// File: sources.f
hw/immu_cfg_pkg.sv
hw/immu_tag_pkg.sv
hw/itlb_spr_decode.sv
hw/itlb_array.sv
hw/immu_fetch_ctrl.sv
hw/immu_top.sv
bench/immu_tb.sv
